// File: logic/controlPkg.sv
package controlPkg;

	localparam int opW = 6;
	localparam int functW = 6;
	localparam int regW = 5;

	typedef enum logic [opW-1:0] {
		opR = 6'd0, opRegimm = 6'd1, opJ = 6'd2, opJal = 6'd3,
		opBeq = 6'd4, opBne = 6'd5, opBlez = 6'd6, opBgtz = 6'd7,
		opAddi = 6'd8, opAddiu = 6'd9, opSlti = 6'd10, opSltiu = 6'd11,
		opAndi = 6'd12, opOri = 6'd13, opXori = 6'd14, opLui = 6'd15,
		opCop0 = 6'd16,
		opLb = 6'd32, opLh = 6'd33, opLw = 6'd35, opLbu = 6'd36, opLhu = 6'd37,
		opSb = 6'd40, opSh = 6'd41, opSw = 6'd43
	} opcodeT;

	typedef enum logic [functW-1:0] {
		functSll = 6'd0, functSrl = 6'd2, functSra = 6'd3,
		functSllv = 6'd4, functSrlv = 6'd6, functSrav = 6'd7,
		functJr = 6'd8, functJalr = 6'd9, functSyscall = 6'd12,
		functEret = 6'd24,
		functAdd = 6'd32, functAddu = 6'd33, functSub = 6'd34, functSubu = 6'd35,
		functAnd = 6'd36, functOr = 6'd37, functXor = 6'd38, functNor = 6'd39,
		functSlt = 6'd42, functSltu = 6'd43
	} functT;

	// rs field selects the cop0 operation
	localparam logic [regW-1:0] rsMfc0 = 5'd0;
	localparam logic [regW-1:0] rsMtc0 = 5'd4;
	localparam logic [regW-1:0] rsEret = 5'd16;

	typedef enum logic [5:0] {
		aluNop, aluAdd, aluAddu, aluSub, aluSubu,
		aluSll, aluSllv, aluSra, aluSrav, aluSrl, aluSrlv,
		aluAnd, aluOr, aluXor, aluNor,
		aluSlt, aluSltu, aluSgt, aluLui, aluJump
	} aluOpT;

	typedef enum logic [1:0] {srcAZero = 2'd0, srcARs = 2'd1, srcAShamt = 2'd2, srcAPc = 2'd3} srcAT;

	typedef enum logic [2:0] {
		srcBRt = 3'd0, srcBSignImm = 3'd2, srcBZeroImm = 3'd4,
		srcBZero = 3'd5, srcBJumpTarget = 3'd6
	} srcBT;

	typedef enum logic [1:0] {regDstRt = 2'd0, regDstRd = 2'd1, regDstRa = 2'd2} regDstT;
	typedef enum logic [1:0] {wbAlu = 2'd0, wbMem = 2'd1, wbLink = 2'd2} wbSrcT;
	typedef enum logic [1:0] {changeSequence = 2'd0, changeJump = 2'd1, changeBranch = 2'd2} changeT;

	typedef enum logic [2:0] {
		loadNone = 3'd0, loadByte = 3'd1, loadByteU = 3'd2,
		loadHalf = 3'd3, loadHalfU = 3'd4, loadWord = 3'd5
	} loadT;

	typedef enum logic [1:0] {storeNone = 2'd0, storeByte = 2'd1, storeHalf = 2'd2, storeWord = 2'd3} storeT;

	typedef struct packed {
		regDstT regDst;
		logic regWrite;
		srcAT aluSrcA;
		srcBT aluSrcB;
		aluOpT aluOp;
		changeT changeType;
		logic memRead;
		logic memWrite;
		wbSrcT memtoReg;
		storeT storeType;
		loadT loadType;
		logic reverse;		// Invert the branch condition
		logic branchTarget;
		logic syscall;
		logic eret;
		logic reservedInstr;
		logic crRead;
		logic crWrite;
	} controlWordT;

	localparam controlWordT nopWord = '0;		// Pipeline bubble

endpackage

// File: logic/rTypeDecoder.sv
`timescale 1ns/1ns

module rTypeDecoder (
	input controlPkg::functT funct,
	output controlPkg::controlWordT word
);

	logic isAlu;
	controlPkg::aluOpT aluOp;

	always_comb
	begin
		isAlu = 1'b1;
		case (funct)
			controlPkg::functSll: aluOp = controlPkg::aluSll;
			controlPkg::functSrl: aluOp = controlPkg::aluSrl;
			controlPkg::functSra: aluOp = controlPkg::aluSra;
			controlPkg::functSllv: aluOp = controlPkg::aluSllv;
			controlPkg::functSrlv: aluOp = controlPkg::aluSrlv;
			controlPkg::functSrav: aluOp = controlPkg::aluSrav;
			controlPkg::functAdd: aluOp = controlPkg::aluAdd;
			controlPkg::functAddu: aluOp = controlPkg::aluAddu;
			controlPkg::functSub: aluOp = controlPkg::aluSub;
			controlPkg::functSubu: aluOp = controlPkg::aluSubu;
			controlPkg::functAnd: aluOp = controlPkg::aluAnd;
			controlPkg::functOr: aluOp = controlPkg::aluOr;
			controlPkg::functXor: aluOp = controlPkg::aluXor;
			controlPkg::functNor: aluOp = controlPkg::aluNor;
			controlPkg::functSlt: aluOp = controlPkg::aluSlt;
			controlPkg::functSltu: aluOp = controlPkg::aluSltu;
			default:
			begin
				isAlu = 1'b0;
				aluOp = controlPkg::aluNop;
			end
		endcase
	end

	always_comb
	begin
		word = controlPkg::nopWord;
		if (isAlu)
		begin
			word.regDst = controlPkg::regDstRd;
			word.regWrite = 1'b1;
			word.aluOp = aluOp;
			word.aluSrcB = controlPkg::srcBRt;
			// Constant shifts take the amount from shamt
			if (funct == controlPkg::functSll || funct == controlPkg::functSra ||
				funct == controlPkg::functSrl)
				word.aluSrcA = controlPkg::srcAShamt;
			else
				word.aluSrcA = controlPkg::srcARs;
		end
		else
		begin
			case (funct)
				controlPkg::functJr, controlPkg::functJalr:
				begin
					word.changeType = controlPkg::changeJump;
					word.aluSrcA = controlPkg::srcARs;
					word.aluSrcB = controlPkg::srcBZero;		// Target is rs + 0
					word.aluOp = controlPkg::aluAdd;
					if (funct == controlPkg::functJalr)
					begin
						word.regDst = controlPkg::regDstRd;
						word.regWrite = 1'b1;
						word.memtoReg = controlPkg::wbLink;
					end
				end
				controlPkg::functSyscall: word.syscall = 1'b1;
				default: word.reservedInstr = 1'b1;
			endcase
		end
	end

endmodule

// File: logic/immDecoder.sv
`timescale 1ns/1ns

module immDecoder (
	input controlPkg::opcodeT op,
	output controlPkg::controlWordT word
);

	always_comb
	begin
		word = controlPkg::nopWord;
		word.regDst = controlPkg::regDstRt;
		word.regWrite = 1'b1;
		word.memtoReg = controlPkg::wbAlu;
		word.changeType = controlPkg::changeSequence;
		word.aluSrcA = controlPkg::srcARs;
		word.aluSrcB = controlPkg::srcBZeroImm;		// Logic ops zero-extend
		case (op)
			controlPkg::opAddi:
			begin
				word.aluOp = controlPkg::aluAdd;
				word.aluSrcB = controlPkg::srcBSignImm;
			end
			controlPkg::opAddiu:
			begin
				word.aluOp = controlPkg::aluAddu;
				word.aluSrcB = controlPkg::srcBSignImm;
			end
			controlPkg::opSlti:
			begin
				word.aluOp = controlPkg::aluSlt;
				word.aluSrcB = controlPkg::srcBSignImm;
			end
			controlPkg::opSltiu: word.aluOp = controlPkg::aluSltu;
			controlPkg::opAndi: word.aluOp = controlPkg::aluAnd;
			controlPkg::opOri: word.aluOp = controlPkg::aluOr;
			controlPkg::opXori: word.aluOp = controlPkg::aluXor;
			controlPkg::opLui:
			begin
				word.aluOp = controlPkg::aluLui;
				word.aluSrcA = controlPkg::srcAZero;
			end
			default:
			begin
				word = controlPkg::nopWord;
				word.reservedInstr = 1'b1;
			end
		endcase
	end

endmodule

// File: logic/memDecoder.sv
`timescale 1ns/1ns

module memDecoder (
	input controlPkg::opcodeT op,
	output controlPkg::controlWordT word
);

	logic isLoad;

	always_comb
	begin
		word = controlPkg::nopWord;
		isLoad = 1'b0;
		case (op)
			controlPkg::opLb: word.loadType = controlPkg::loadByte;
			controlPkg::opLbu: word.loadType = controlPkg::loadByteU;
			controlPkg::opLh: word.loadType = controlPkg::loadHalf;
			controlPkg::opLhu: word.loadType = controlPkg::loadHalfU;
			controlPkg::opLw: word.loadType = controlPkg::loadWord;
			controlPkg::opSb: word.storeType = controlPkg::storeByte;
			controlPkg::opSh: word.storeType = controlPkg::storeHalf;
			controlPkg::opSw: word.storeType = controlPkg::storeWord;
			default: word.reservedInstr = 1'b1;
		endcase
		isLoad = word.loadType != controlPkg::loadNone;
		if (!word.reservedInstr)
		begin
			word.aluSrcA = controlPkg::srcARs;		// Address is rs + signImm
			word.aluSrcB = controlPkg::srcBSignImm;
			word.aluOp = controlPkg::aluAdd;
			word.memRead = isLoad;
			word.memWrite = !isLoad;
			if (isLoad)
			begin
				word.regDst = controlPkg::regDstRt;
				word.regWrite = 1'b1;
				word.memtoReg = controlPkg::wbMem;
			end
		end
	end

endmodule

// File: logic/flowDecoder.sv
`timescale 1ns/1ns

module flowDecoder (
	input controlPkg::opcodeT op,
	input logic [controlPkg::regW-1:0] rt,
	output controlPkg::controlWordT word
);

	always_comb
	begin
		word = controlPkg::nopWord;
		case (op)
			controlPkg::opBeq, controlPkg::opBne:
			begin
				word.aluSrcB = controlPkg::srcBRt;
				word.aluOp = controlPkg::aluSub;		// Equal when difference is zero
				word.reverse = op == controlPkg::opBne;
			end
			controlPkg::opBlez, controlPkg::opBgtz:
			begin
				word.aluSrcB = controlPkg::srcBZero;
				word.aluOp = controlPkg::aluSgt;
				word.reverse = op == controlPkg::opBgtz;
			end
			controlPkg::opRegimm:
			begin
				if (rt == 5'd0 || rt == 5'd1)
				begin
					word.aluSrcB = controlPkg::srcBZero;
					word.aluOp = controlPkg::aluSlt;
					word.reverse = rt[0];		// bgez
				end
				else
					word.reservedInstr = 1'b1;
			end
			controlPkg::opJ, controlPkg::opJal:
			begin
				word.changeType = controlPkg::changeJump;
				word.aluSrcA = controlPkg::srcAPc;
				word.aluSrcB = controlPkg::srcBJumpTarget;
				word.aluOp = controlPkg::aluJump;
				if (op == controlPkg::opJal)
				begin
					word.regDst = controlPkg::regDstRa;
					word.regWrite = 1'b1;
					word.memtoReg = controlPkg::wbLink;
				end
			end
			default: word.reservedInstr = 1'b1;
		endcase
		// Common branch fields
		if (word.aluOp == controlPkg::aluSub || word.aluOp == controlPkg::aluSgt ||
			word.aluOp == controlPkg::aluSlt)
		begin
			word.changeType = controlPkg::changeBranch;
			word.branchTarget = 1'b1;
			word.aluSrcA = controlPkg::srcARs;
		end
	end

endmodule

// File: logic/cop0Decoder.sv
`timescale 1ns/1ns

module cop0Decoder (
	input logic [controlPkg::regW-1:0] rs,
	input controlPkg::functT funct,
	output controlPkg::controlWordT word
);

	always_comb
	begin
		word = controlPkg::nopWord;
		case (rs)
			controlPkg::rsMfc0:
			begin
				word.crRead = 1'b1;
				word.regWrite = 1'b1;
				word.regDst = controlPkg::regDstRt;
			end
			controlPkg::rsMtc0: word.crWrite = 1'b1;
			controlPkg::rsEret:
			begin
				if (funct == controlPkg::functEret)
					word.eret = 1'b1;
				else
					word.reservedInstr = 1'b1;		// CO space, other functs
			end
			default: word.reservedInstr = 1'b1;
		endcase
	end

endmodule

// File: logic/controlUnit.sv
`timescale 1ns/1ns

module controlUnit (
	input logic clk,
	input logic reset,
	input logic instrValid,
	input logic [31:0] instr,
	output logic ctrlValid,
	output controlPkg::controlWordT ctrl
);

	controlPkg::opcodeT op;
	controlPkg::functT funct;
	logic [controlPkg::regW-1:0] rs;
	logic [controlPkg::regW-1:0] rt;

	controlPkg::controlWordT rWord;
	controlPkg::controlWordT immWord;
	controlPkg::controlWordT memWord;
	controlPkg::controlWordT flowWord;
	controlPkg::controlWordT cop0Word;
	controlPkg::controlWordT nextWord;

	assign op = controlPkg::opcodeT'(instr[31 -: controlPkg::opW]);
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign funct = controlPkg::functT'(instr[controlPkg::functW-1:0]);

	rTypeDecoder u_rType (.funct(funct), .word(rWord));
	immDecoder u_imm (.op(op), .word(immWord));
	memDecoder u_mem (.op(op), .word(memWord));
	flowDecoder u_flow (.op(op), .rt(rt), .word(flowWord));
	cop0Decoder u_cop0 (.rs(rs), .funct(funct), .word(cop0Word));

	// Opcode class picks the sub-decoder
	always_comb
	begin
		case (op)
			controlPkg::opR: nextWord = rWord;
			controlPkg::opAddi, controlPkg::opAddiu, controlPkg::opSlti,
			controlPkg::opSltiu, controlPkg::opAndi, controlPkg::opOri,
			controlPkg::opXori, controlPkg::opLui:
				nextWord = immWord;
			controlPkg::opLb, controlPkg::opLbu, controlPkg::opLh,
			controlPkg::opLhu, controlPkg::opLw, controlPkg::opSb,
			controlPkg::opSh, controlPkg::opSw:
				nextWord = memWord;
			controlPkg::opRegimm, controlPkg::opBeq, controlPkg::opBne,
			controlPkg::opBlez, controlPkg::opBgtz, controlPkg::opJ,
			controlPkg::opJal:
				nextWord = flowWord;
			controlPkg::opCop0: nextWord = cop0Word;
			default:
			begin
				nextWord = controlPkg::nopWord;
				nextWord.reservedInstr = 1'b1;		// Unknown opcode
			end
		endcase
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			ctrlValid <= 1'b0;
			ctrl <= controlPkg::nopWord;
		end
		else
		begin
			ctrlValid <= instrValid;
			ctrl <= instrValid ? nextWord : controlPkg::nopWord;		// Bubble when idle
		end
	end

endmodule

// File: include/controlModel.svh
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// Expected control word for one instruction
function automatic controlPkg::controlWordT expectedWord(input logic [31:0] instr);
	controlPkg::controlWordT w;
	logic [5:0] op;
	logic [5:0] fn;
	logic [4:0] rs;
	logic [4:0] rt;
	op = instr[31:26];
	rs = instr[25:21];
	rt = instr[20:16];
	fn = instr[5:0];
	w = controlPkg::nopWord;
	case (op)
		6'd0:
		begin
			case (fn)
				6'd0: w.aluOp = controlPkg::aluSll;
				6'd2: w.aluOp = controlPkg::aluSrl;
				6'd3: w.aluOp = controlPkg::aluSra;
				6'd4: w.aluOp = controlPkg::aluSllv;
				6'd6: w.aluOp = controlPkg::aluSrlv;
				6'd7: w.aluOp = controlPkg::aluSrav;
				6'd32: w.aluOp = controlPkg::aluAdd;
				6'd33: w.aluOp = controlPkg::aluAddu;
				6'd34: w.aluOp = controlPkg::aluSub;
				6'd35: w.aluOp = controlPkg::aluSubu;
				6'd36: w.aluOp = controlPkg::aluAnd;
				6'd37: w.aluOp = controlPkg::aluOr;
				6'd38: w.aluOp = controlPkg::aluXor;
				6'd39: w.aluOp = controlPkg::aluNor;
				6'd42: w.aluOp = controlPkg::aluSlt;
				6'd43: w.aluOp = controlPkg::aluSltu;
				6'd8, 6'd9:
				begin
					w.changeType = controlPkg::changeJump;
					w.aluSrcA = controlPkg::srcARs;
					w.aluSrcB = controlPkg::srcBZero;
					w.aluOp = controlPkg::aluAdd;
				end
				6'd12: w.syscall = 1'b1;
				default: w.reservedInstr = 1'b1;
			endcase
			if (fn == 6'd9 || (fn != 6'd8 && w.aluOp != controlPkg::aluNop))
			begin
				w.regDst = controlPkg::regDstRd;
				w.regWrite = 1'b1;
				w.memtoReg = fn == 6'd9 ? controlPkg::wbLink : controlPkg::wbAlu;
			end
			if (fn != 6'd8 && fn != 6'd9 && w.aluOp != controlPkg::aluNop)
				w.aluSrcA = fn < 6'd4 ? controlPkg::srcAShamt : controlPkg::srcARs;
		end
		6'd8, 6'd9, 6'd10, 6'd11, 6'd12, 6'd13, 6'd14, 6'd15:
		begin
			w.regWrite = 1'b1;
			w.aluSrcA = op == 6'd15 ? controlPkg::srcAZero : controlPkg::srcARs;
			w.aluSrcB = op < 6'd11 ? controlPkg::srcBSignImm : controlPkg::srcBZeroImm;
			case (op)
				6'd8: w.aluOp = controlPkg::aluAdd;
				6'd9: w.aluOp = controlPkg::aluAddu;
				6'd10: w.aluOp = controlPkg::aluSlt;
				6'd11: w.aluOp = controlPkg::aluSltu;
				6'd12: w.aluOp = controlPkg::aluAnd;
				6'd13: w.aluOp = controlPkg::aluOr;
				6'd14: w.aluOp = controlPkg::aluXor;
				default: w.aluOp = controlPkg::aluLui;
			endcase
		end
		6'd32, 6'd33, 6'd35, 6'd36, 6'd37:
		begin
			w.aluSrcA = controlPkg::srcARs;
			w.aluSrcB = controlPkg::srcBSignImm;
			w.aluOp = controlPkg::aluAdd;
			w.memRead = 1'b1;
			w.regWrite = 1'b1;
			w.memtoReg = controlPkg::wbMem;
			case (op)
				6'd32: w.loadType = controlPkg::loadByte;
				6'd33: w.loadType = controlPkg::loadHalf;
				6'd35: w.loadType = controlPkg::loadWord;
				6'd36: w.loadType = controlPkg::loadByteU;
				default: w.loadType = controlPkg::loadHalfU;
			endcase
		end
		6'd40, 6'd41, 6'd43:
		begin
			w.aluSrcA = controlPkg::srcARs;
			w.aluSrcB = controlPkg::srcBSignImm;
			w.aluOp = controlPkg::aluAdd;
			w.memWrite = 1'b1;
			case (op)
				6'd40: w.storeType = controlPkg::storeByte;
				6'd41: w.storeType = controlPkg::storeHalf;
				default: w.storeType = controlPkg::storeWord;
			endcase
		end
		6'd1, 6'd4, 6'd5, 6'd6, 6'd7:
		begin
			if (op == 6'd1 && rt > 5'd1)
				w.reservedInstr = 1'b1;
			else
			begin
				w.changeType = controlPkg::changeBranch;
				w.branchTarget = 1'b1;
				w.aluSrcA = controlPkg::srcARs;
				w.aluSrcB = op < 6'd6 && op != 6'd1 ? controlPkg::srcBRt : controlPkg::srcBZero;
				case (op)
					6'd4, 6'd5: w.aluOp = controlPkg::aluSub;
					6'd6, 6'd7: w.aluOp = controlPkg::aluSgt;
					default: w.aluOp = controlPkg::aluSlt;
				endcase
				w.reverse = op == 6'd1 ? rt[0] : op[0];
			end
		end
		6'd2, 6'd3:
		begin
			w.changeType = controlPkg::changeJump;
			w.aluSrcA = controlPkg::srcAPc;
			w.aluSrcB = controlPkg::srcBJumpTarget;
			w.aluOp = controlPkg::aluJump;
			if (op == 6'd3)
			begin
				w.regDst = controlPkg::regDstRa;
				w.regWrite = 1'b1;
				w.memtoReg = controlPkg::wbLink;
			end
		end
		6'd16:
		begin
			if (rs == 5'd0)
			begin
				w.crRead = 1'b1;
				w.regWrite = 1'b1;
			end
			else if (rs == 5'd4)
				w.crWrite = 1'b1;
			else if (rs == 5'd16 && fn == 6'd24)
				w.eret = 1'b1;
			else
				w.reservedInstr = 1'b1;
		end
		default: w.reservedInstr = 1'b1;
	endcase
	return w;
endfunction

`endif

// File: test/controlUnitTb.sv
`timescale 1ns/1ns

module controlUnitTb;

	`include "controlModel.svh"

	localparam int resetCycles = 5;
	localparam int legalCount = 400;
	localparam int reservedCount = 120;
	localparam int mixedCount = 200;
	localparam int totalCycles = resetCycles + 1 + legalCount + reservedCount + mixedCount + 6;
	localparam int timeoutNs = (totalCycles + 100) * 8;

	logic clk = 1'b0;
	logic reset;
	logic instrValid;
	logic [31:0] instr;
	logic ctrlValid;
	controlPkg::controlWordT ctrl;

	integer seed = 7258;
	int errors = 0;
	int checks = 0;

	logic [5:0] legalOps [$];
	logic [5:0] legalFuncts [$];
	logic [4:0] cop0Rs [$];

	// One result in flight at a time
	controlPkg::controlWordT expQ [$];
	logic validQ [$];
	string nameQ [$];

	controlUnit u_dut (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.ctrlValid(ctrlValid),
		.ctrl(ctrl)
	);

	always #4 clk = ~clk;

	function automatic int pick(input int n);
		return {$random(seed)} % n;
	endfunction

	function automatic bit knownOp(input logic [5:0] v);
		foreach (legalOps[i])
			if (legalOps[i] == v)
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic bit knownFunct(input logic [5:0] v);
		foreach (legalFuncts[i])
			if (legalFuncts[i] == v)
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic logic [31:0] randomLegal();
		logic [31:0] w;
		w = $random(seed);
		w[31:26] = legalOps[pick(legalOps.size())];
		if (w[31:26] == 6'd0)
			w[5:0] = legalFuncts[pick(legalFuncts.size())];
		else if (w[31:26] == 6'd1)
			w[20:17] = 4'd0;		// bltz or bgez
		else if (w[31:26] == 6'd16)
		begin
			w[25:21] = cop0Rs[pick(3)];
			if (w[25:21] == 5'd16)
				w[5:0] = 6'd24;
		end
		return w;
	endfunction

	function automatic logic [31:0] randomReserved();
		logic [31:0] w;
		int kind;
		w = $random(seed);
		kind = pick(5);
		case (kind)
			0:
				while (knownOp(w[31:26]))
					w[31:26] = w[31:26] + 6'd1;
			1:
			begin
				w[31:26] = 6'd0;
				while (knownFunct(w[5:0]))
					w[5:0] = w[5:0] + 6'd1;
			end
			2:
			begin
				w[31:26] = 6'd1;
				if (w[20:17] == 4'd0)
					w[20] = 1'b1;		// Keep rt above 1
			end
			3:
			begin
				w[31:26] = 6'd16;
				while (w[25:21] == 5'd0 || w[25:21] == 5'd4 || w[25:21] == 5'd16)
					w[25:21] = w[25:21] + 5'd1;
			end
			default:
			begin
				w[31:26] = 6'd16;
				w[25:21] = 5'd16;
				if (w[5:0] == 6'd24)
					w[5:0] = 6'd25;
			end
		endcase
		return w;
	endfunction

	task automatic compare(input logic expValid, input controlPkg::controlWordT expWord,
		input string name);
		checks++;
		assert (ctrlValid === expValid)
		else
		begin
			errors++;
			$display("FAILED %s ctrlValid: expected %0b, actual %0b", name, expValid, ctrlValid);
		end
		assert (ctrl === expWord)
		else
		begin
			errors++;
			$display("FAILED %s ctrl: expected %h, actual %h", name, expWord, ctrl);
		end
	endtask

	task automatic stepExpect(input logic valid, input logic [31:0] word,
		input controlPkg::controlWordT exp, input string name);
		instrValid = valid;
		instr = word;
		expQ.push_back(exp);
		validQ.push_back(valid);
		nameQ.push_back(name);
		@(posedge clk);
		#1;
		compare(validQ.pop_front(), expQ.pop_front(), nameQ.pop_front());
	endtask

	task automatic step(input logic valid, input logic [31:0] word, input string name);
		controlPkg::controlWordT exp;
		exp = valid ? expectedWord(word) : controlPkg::nopWord;
		stepExpect(valid, word, exp, name);
	endtask

	// Watchdog
	initial
	begin
		#(timeoutNs);
		$display("Timeout: the run did not finish within %0d ns", timeoutNs);
		$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		controlPkg::controlWordT resWord;
		legalOps = '{6'd0, 6'd1, 6'd2, 6'd3, 6'd4, 6'd5, 6'd6, 6'd7, 6'd8, 6'd9,
			6'd10, 6'd11, 6'd12, 6'd13, 6'd14, 6'd15, 6'd16,
			6'd32, 6'd33, 6'd35, 6'd36, 6'd37, 6'd40, 6'd41, 6'd43};
		legalFuncts = '{6'd0, 6'd2, 6'd3, 6'd4, 6'd6, 6'd7, 6'd8, 6'd9, 6'd12,
			6'd32, 6'd33, 6'd34, 6'd35, 6'd36, 6'd37, 6'd38, 6'd39, 6'd42, 6'd43};
		cop0Rs = '{5'd0, 5'd4, 5'd16};
		resWord = controlPkg::nopWord;
		resWord.reservedInstr = 1'b1;
		reset = 1'b0;
		instrValid = 1'b1;		// Valid words during reset must not reach ctrl
		instr = randomLegal();

		repeat (resetCycles)
		begin
			@(posedge clk);
			#1;
			compare(1'b0, controlPkg::nopWord, "reset");
			instr = randomLegal();
		end
		reset = 1'b1;
		step(1'b0, $random(seed), "reset release");

		repeat (legalCount)
			step(1'b1, randomLegal(), "legal");

		repeat (reservedCount)
			stepExpect(1'b1, randomReserved(), resWord, "reserved");

		repeat (mixedCount)
		begin
			if (pick(4) == 0)
				step(1'b0, $random(seed), "idle");		// instr still moves
			else
				step(1'b1, randomLegal(), "mixed");
		end

		// Second word must not inherit fields from the first
		step(1'b1, {6'd3, 26'h0123456}, "jal");
		step(1'b1, {6'd0, 5'd31, 15'd0, 6'd8}, "jr after jal");
		step(1'b1, {6'd43, 5'd29, 5'd8, 16'h0010}, "sw");
		step(1'b1, {6'd35, 5'd29, 5'd9, 16'h0010}, "lw after sw");
		step(1'b1, {6'd16, 5'd0, 5'd8, 5'd12, 11'd0}, "mfc0");
		step(1'b1, {26'd0, 6'd12}, "syscall after mfc0");

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: flist.f
+incdir+include
logic/controlPkg.sv
logic/rTypeDecoder.sv
logic/immDecoder.sv
logic/memDecoder.sv
logic/flowDecoder.sv
logic/cop0Decoder.sv
logic/controlUnit.sv
test/controlUnitTb.sv

// File: run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" &&
	rm -f sim.log &&
	verilator --binary --assert -f flist.f --top-module controlUnitTb -o controlUnitTb &&
	./obj_dir/controlUnitTb | tee sim.log &&
	grep -q "=== PASS ===" sim.log ||
	{ echo "Simulation did not pass"; exit 1; }

echo "Simulation passed"
